// ==== verilog/primitive_pkg.sv ====
/* Primitive buffer definitions */

`default_nettype none

package primitive_pkg;

   // ==============================
   // Sizes
   // ==============================
   localparam int NUM_LANES       = 5;
   localparam int BLOCK_WIDTH     = 256;
   localparam int WORD_WIDTH      = 32;
   localparam int WORDS_PER_BLOCK = BLOCK_WIDTH / WORD_WIDTH;
   localparam int LANE_DEPTH      = 16;
   localparam int LEVEL_WIDTH     = 5;    // Store plus the block in the serializer
   localparam int LOW_WATERMARK   = 4;    // Ask for more below this many blocks

   // Startup and marker timing, in clk_pll_200 cycles
   localparam int RESET_HOLD_CYCLES  = 16;
   localparam int RESET_PULSE_CYCLES = 32;
   localparam int MARKER_CYCLES      = 4;

   // ==============================
   // Payload and port types
   // ==============================
   typedef logic [BLOCK_WIDTH-1:0] block_t;
   typedef logic [WORD_WIDTH-1:0]  word_t;

   typedef struct packed {
      logic   req;
      block_t data;
   } block_write_t;

   typedef struct packed {
      word_t word;
      logic  empty;
   } word_out_t;

endpackage

`default_nettype wire

// ==== verilog/lane_store.sv ====
/* Lane block store */

`timescale 1ns/1ns
`default_nettype none

module lane_store (
   input  wire                         clk_pll_200,
   input  wire                         rst_n,
   input  wire primitive_pkg::block_write_t wr,
   input  wire                         take,
   output logic                        wr_ack,
   output primitive_pkg::block_t       head,
   output logic                        head_valid
);

   typedef logic [$clog2(primitive_pkg::LANE_DEPTH)-1:0] ptr_t;
   typedef logic [primitive_pkg::LEVEL_WIDTH-1:0] count_t;
   typedef enum logic {ack_wait, ack_hold} ack_state_t;

   primitive_pkg::block_t mem [primitive_pkg::LANE_DEPTH];
   ptr_t       wr_ptr;
   ptr_t       rd_ptr;
   count_t     count;
   ack_state_t ack_state;
   logic       full;
   logic       store;

   assign full  = count == count_t'(primitive_pkg::LANE_DEPTH);
   assign store = (ack_state == ack_wait) && wr.req && !full;   // Full holds off the ack

   always_ff @(posedge clk_pll_200) begin
      if (!rst_n) begin
         ack_state <= ack_wait;
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
      end else begin
         // Four-phase acceptance
         case (ack_state)
            ack_wait: if (store) ack_state <= ack_hold;
            ack_hold: if (!wr.req) ack_state <= ack_wait;
            default:  ack_state <= ack_wait;
         endcase
         if (store) wr_ptr <= wr_ptr + ptr_t'(1);
         if (take) rd_ptr <= rd_ptr + ptr_t'(1);
         case ({store, take})
            2'b10:   count <= count + count_t'(1);
            2'b01:   count <= count - count_t'(1);
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk_pll_200) begin
      if (store) mem[wr_ptr] <= wr.data;
   end

   assign wr_ack     = ack_state == ack_hold;
   assign head       = mem[rd_ptr];
   assign head_valid = count != '0;

endmodule

`default_nettype wire

// ==== verilog/word_serializer.sv ====
/* Block to word serializer */

`timescale 1ns/1ns
`default_nettype none

module word_serializer (
   input  wire                          clk_pll_200,
   input  wire                          rst_n,
   input  wire primitive_pkg::block_t   head,
   input  wire                          head_valid,
   input  wire                          pop,
   output logic                         take,
   output primitive_pkg::word_out_t     rd,
   output logic                         block_done
);

   typedef logic [$clog2(primitive_pkg::WORDS_PER_BLOCK)-1:0] idx_t;

   primitive_pkg::block_t cur_block;
   idx_t idx;
   logic loaded;
   logic last_pop;

   assign last_pop   = loaded && pop && (idx == idx_t'(primitive_pkg::WORDS_PER_BLOCK - 1));
   assign take       = head_valid && (!loaded || last_pop);   // No gap between blocks
   assign block_done = last_pop;

   always_ff @(posedge clk_pll_200) begin
      if (!rst_n) begin
         loaded <= 1'b0;
         idx    <= '0;
      end else if (take) begin
         loaded <= 1'b1;
         idx    <= '0;
      end else if (loaded && pop) begin
         if (last_pop) loaded <= 1'b0;
         idx <= last_pop ? '0 : idx + idx_t'(1);
      end
   end

   always_ff @(posedge clk_pll_200) begin
      if (take) cur_block <= head;
   end

   // Low word first
   assign rd.word  = cur_block[idx*primitive_pkg::WORD_WIDTH +: primitive_pkg::WORD_WIDTH];
   assign rd.empty = !loaded;

endmodule

`default_nettype wire

// ==== verilog/primitive_lane.sv ====
/* Primitive lane */

`timescale 1ns/1ns
`default_nettype none

module primitive_lane (
   input  wire                          clk_pll_200,
   input  wire                          rst_n,
   input  wire                          burst,
   input  wire primitive_pkg::block_write_t wr,
   input  wire                          pop,
   output logic                         wr_ack,
   output primitive_pkg::word_out_t     rd,
   output logic                         refill
);

   typedef logic [primitive_pkg::LEVEL_WIDTH-1:0] level_t;

   primitive_pkg::block_t head;
   logic   head_valid;
   logic   take;
   logic   block_done;
   logic   ack_q;
   logic   accepted;
   level_t level;

   lane_store store (
      .clk_pll_200 (clk_pll_200),
      .rst_n       (rst_n),
      .wr          (wr),
      .take        (take),
      .wr_ack      (wr_ack),
      .head        (head),
      .head_valid  (head_valid)
   );

   word_serializer serializer (
      .clk_pll_200 (clk_pll_200),
      .rst_n       (rst_n),
      .head        (head),
      .head_valid  (head_valid),
      .pop         (pop),
      .take        (take),
      .rd          (rd),
      .block_done  (block_done)
   );

   assign accepted = wr_ack && !ack_q;   // Ack rise means one new block

   // ==============================
   // Fill level and refill request
   // ==============================
   always_ff @(posedge clk_pll_200) begin
      if (!rst_n) begin
         ack_q  <= 1'b0;
         level  <= '0;
         refill <= 1'b0;
      end else begin
         ack_q <= wr_ack;
         case ({accepted, block_done})
            2'b10:   level <= level + level_t'(1);
            2'b01:   level <= level - level_t'(1);
            default: level <= level;
         endcase
         refill <= burst && (level < level_t'(primitive_pkg::LOW_WATERMARK));
      end
   end

endmodule

`default_nettype wire

// ==== verilog/burst_marker.sv ====
/* Burst marker generator */

`timescale 1ns/1ns
`default_nettype none

module burst_marker (
   input  wire  clk_pll_200,
   input  wire  rst_n,
   input  wire  burst,
   output logic ecrst,
   output logic bcrst
);

   typedef logic [$clog2(primitive_pkg::MARKER_CYCLES + 1)-1:0] cnt_t;

   logic burst_q;
   logic start_kind;   // High for start of burst
   cnt_t cnt;

   always_ff @(posedge clk_pll_200) begin
      if (!rst_n) begin
         burst_q    <= 1'b0;
         start_kind <= 1'b0;
         cnt        <= '0;
      end else begin
         burst_q <= burst;
         if (burst != burst_q) begin
            // Any edge restarts the marker
            start_kind <= burst;
            cnt        <= cnt_t'(primitive_pkg::MARKER_CYCLES);
         end else if (cnt != '0) begin
            cnt <= cnt - cnt_t'(1);
         end
      end
   end

   // Start of burst 11, end of burst 10
   assign ecrst = cnt != '0;
   assign bcrst = (cnt != '0) && start_kind;

endmodule

`default_nettype wire

// ==== verilog/reset_sequencer.sv ====
/* Startup reset sequencer */

`timescale 1ns/1ns
`default_nettype none

module reset_sequencer (
   input  wire  clk_pll_200,
   input  wire  rst_n,
   input  wire  flush,
   output logic core_rst_n,
   output logic sys_ready
);

   typedef enum logic [1:0] {st_hold, st_pulse, st_run} state_t;
   typedef logic [$clog2(primitive_pkg::RESET_HOLD_CYCLES +
                         primitive_pkg::RESET_PULSE_CYCLES)-1:0] cnt_t;

   state_t state;
   cnt_t   cnt;

   always_ff @(posedge clk_pll_200) begin
      if (!rst_n || flush) begin
         state <= st_hold;   // Flush restarts the whole sequence
         cnt   <= '0;
      end else begin
         case (state)
            st_hold:
               if (cnt == cnt_t'(primitive_pkg::RESET_HOLD_CYCLES - 1)) begin
                  state <= st_pulse;
                  cnt   <= '0;
               end else begin
                  cnt <= cnt + cnt_t'(1);
               end
            st_pulse:
               if (cnt == cnt_t'(primitive_pkg::RESET_PULSE_CYCLES - 1)) begin
                  state <= st_run;
                  cnt   <= '0;
               end else begin
                  cnt <= cnt + cnt_t'(1);
               end
            default: state <= st_run;
         endcase
      end
   end

   assign sys_ready  = state == st_run;
   assign core_rst_n = (state == st_run) && !flush;

endmodule

`default_nettype wire

// ==== verilog/l0_buffer_top.sv ====
/* L0 primitive buffer top */

`timescale 1ns/1ns
`default_nettype none

module l0_buffer_top (
   input  wire  clk_pll_200,
   input  wire  rst_n,
   input  wire  burst,
   input  wire  flush,
   input  wire  primitive_pkg::block_write_t [primitive_pkg::NUM_LANES-1:0] wr,
   input  wire  [primitive_pkg::NUM_LANES-1:0] pop,
   output logic [primitive_pkg::NUM_LANES-1:0] wr_ack,
   output primitive_pkg::word_out_t [primitive_pkg::NUM_LANES-1:0] rd,
   output logic [primitive_pkg::NUM_LANES-1:0] refill,
   output logic ecrst,
   output logic bcrst,
   output logic sys_ready
);

   logic core_rst_n;   // Also forced low by flush

   reset_sequencer sequencer (
      .clk_pll_200 (clk_pll_200),
      .rst_n       (rst_n),
      .flush       (flush),
      .core_rst_n  (core_rst_n),
      .sys_ready   (sys_ready)
   );

   burst_marker marker (
      .clk_pll_200 (clk_pll_200),
      .rst_n       (core_rst_n),
      .burst       (burst),
      .ecrst       (ecrst),
      .bcrst       (bcrst)
   );

   // ==============================
   // Primitive lanes
   // ==============================
   for (genvar i = 0; i < primitive_pkg::NUM_LANES; i++) begin : g_lane
      primitive_lane lane (
         .clk_pll_200 (clk_pll_200),
         .rst_n       (core_rst_n),
         .burst       (burst),
         .wr          (wr[i]),
         .pop         (pop[i]),
         .wr_ack      (wr_ack[i]),
         .rd          (rd[i]),
         .refill      (refill[i])
      );
   end

endmodule

`default_nettype wire

// ==== bench/l0_buffer_properties.sv ====
/* Write port protocol checks */

`timescale 1ns/1ns
`default_nettype none

module l0_buffer_properties (
   input wire clk_pll_200,
   input wire rst_n,
   input wire primitive_pkg::block_write_t [primitive_pkg::NUM_LANES-1:0] wr,
   input wire [primitive_pkg::NUM_LANES-1:0] wr_ack,
   input wire sys_ready
);

   for (genvar i = 0; i < primitive_pkg::NUM_LANES; i++) begin : g_chk
      ack_rise: assert property (@(posedge clk_pll_200) disable iff (!rst_n)
         $rose(wr_ack[i]) |-> $past(wr[i].req))
         else $error("ack rose without req on lane %0d", i);
      ack_fall: assert property (@(posedge clk_pll_200) disable iff (!rst_n)
         $fell(wr_ack[i]) |-> !$past(wr[i].req))
         else $error("ack fell before req on lane %0d", i);
      // Writer holds data until the ack
      data_hold: assert property (@(posedge clk_pll_200) disable iff (!rst_n)
         (wr[i].req && !wr_ack[i]) |=> $stable(wr[i].data))
         else $error("write data changed while waiting on lane %0d", i);
      ack_ready: assert property (@(posedge clk_pll_200) disable iff (!rst_n)
         !sys_ready |-> !wr_ack[i])
         else $error("ack before system ready on lane %0d", i);
   end

endmodule

bind l0_buffer_top l0_buffer_properties props0 (
   .clk_pll_200 (clk_pll_200),
   .rst_n       (rst_n),
   .wr          (wr),
   .wr_ack      (wr_ack),
   .sys_ready   (sys_ready)
);

`default_nettype wire

// ==== bench/tb_l0_buffer.sv ====
/* L0 buffer testbench */

`timescale 1ns/1ns
`default_nettype none

module tb_l0_buffer;

   localparam int NL = primitive_pkg::NUM_LANES;
   localparam int START_CYCLES = primitive_pkg::RESET_HOLD_CYCLES +
                                 primitive_pkg::RESET_PULSE_CYCLES;

   logic clk_pll_200 = 1'b0;
   logic rst_n, burst, flush, ecrst, bcrst, sys_ready;
   primitive_pkg::block_write_t [NL-1:0] wr;
   primitive_pkg::word_out_t [NL-1:0] rd;
   logic [NL-1:0] pop = '0;
   logic [NL-1:0] wr_ack, refill, ack_now, ack_prev, exp_empty, exp_refill;
   primitive_pkg::word_t ref_q [NL][$];
   primitive_pkg::word_t exp_word [NL];
   int ref_level [NL];
   int words_popped [NL];
   int since_reset = 0, mk_left = 0, manual_target = 0, manual_done = 0;
   logic model_ready = 1'b0, mk_start = 1'b0, burst_d = 1'b0, pop_random;
   logic [31:0] data_lfsr = 32'h459f;
   logic [31:0] pop_lfsr = 32'h459f;

   l0_buffer_top dut0 (.clk_pll_200(clk_pll_200), .rst_n(rst_n), .burst(burst), .flush(flush),
      .wr(wr), .pop(pop), .wr_ack(wr_ack), .rd(rd), .refill(refill), .ecrst(ecrst),
      .bcrst(bcrst), .sys_ready(sys_ready));

   always #10 clk_pll_200 = !clk_pll_200;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   task automatic report_value(input string name, input int lane, input logic [31:0] expv,
                               input logic [31:0] actv);
      $display("FAIL time=%0t %s lane %0d expected %h actual %h", $time, name, lane, expv, actv);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch");
   endtask

   task automatic report_problem(input string msg);
      $display("Error at %0t: %s", $time, msg);
      $display("TEST RESULT: FAIL");
      $fatal(1, "run aborted");
   endtask

   // ==============================
   // Reference model
   // ==============================
   always @(negedge clk_pll_200) ack_now <= wr_ack;   // Settled ack of this cycle

   always @(posedge clk_pll_200) begin
      logic core_run;
      core_run = model_ready && !flush;
      for (int i = 0; i < NL; i++) begin
         if (!core_run) begin
            ref_q[i].delete();
            ref_level[i] = 0;
            words_popped[i] = 0;
            exp_refill[i] <= 1'b0;
         end else begin
            exp_refill[i] <= burst && (ref_level[i] < primitive_pkg::LOW_WATERMARK);
            if (pop[i] && !exp_empty[i]) begin
               void'(ref_q[i].pop_front());
               words_popped[i]++;
               if (words_popped[i] % primitive_pkg::WORDS_PER_BLOCK == 0) ref_level[i]--;
            end
            if (ack_now[i] && !ack_prev[i]) begin   // Accepted block goes in low word first
               for (int w = 0; w < primitive_pkg::WORDS_PER_BLOCK; w++)
                  ref_q[i].push_back(wr[i].data[w*primitive_pkg::WORD_WIDTH +: 32]);
               ref_level[i]++;
            end
         end
         ack_prev[i] <= ack_now[i];
         exp_empty[i] <= ref_q[i].size() == 0;
         exp_word[i] <= (ref_q[i].size() != 0) ? ref_q[i][0] : '0;
      end
      // Burst markers
      burst_d <= core_run ? burst : 1'b0;
      if (!core_run) mk_left <= 0;
      else if (burst != burst_d) begin
         mk_left  <= primitive_pkg::MARKER_CYCLES;
         mk_start <= burst;
      end else if (mk_left > 0) mk_left <= mk_left - 1;
      if (!rst_n || flush) since_reset <= 0;
      else if (since_reset < START_CYCLES) since_reset <= since_reset + 1;
      model_ready <= rst_n && !flush && (since_reset + 1 >= START_CYCLES);
   end

   // ==============================
   // Checks
   // ==============================
   ready_chk: assert property (@(posedge clk_pll_200) disable iff (!rst_n) sys_ready == model_ready)
      else report_value("sys_ready", 0, 32'(model_ready), 32'(sys_ready));
   ecrst_chk: assert property (@(posedge clk_pll_200) disable iff (!rst_n) ecrst == (mk_left != 0))
      else report_value("ecrst", 0, 32'(mk_left != 0), 32'(ecrst));
   bcrst_chk: assert property (@(posedge clk_pll_200) disable iff (!rst_n)
      bcrst == ((mk_left != 0) && mk_start))
      else report_value("bcrst", 0, 32'((mk_left != 0) && mk_start), 32'(bcrst));

   for (genvar i = 0; i < NL; i++) begin : g_chk
      empty_chk: assert property (@(posedge clk_pll_200) disable iff (!rst_n)
         rd[i].empty == exp_empty[i])
         else report_value("rd.empty", i, 32'(exp_empty[i]), 32'(rd[i].empty));
      word_chk: assert property (@(posedge clk_pll_200) disable iff (!rst_n)
         (pop[i] && !rd[i].empty) |-> rd[i].word == exp_word[i])
         else report_value("rd.word", i, exp_word[i], rd[i].word);
      refill_chk: assert property (@(posedge clk_pll_200) disable iff (!rst_n)
         refill[i] == exp_refill[i])
         else report_value("refill", i, 32'(exp_refill[i]), 32'(refill[i]));
      full_chk: assert property (@(posedge clk_pll_200) disable iff (!rst_n)
         $rose(wr_ack[i]) |-> $past(ref_level[i]) <= primitive_pkg::LANE_DEPTH)
         else report_problem("block accepted while lane was full");
   end

   // ==============================
   // Stimulus
   // ==============================
   always @(negedge clk_pll_200) begin
      for (int i = 0; i < NL; i++) begin
         if (pop_random) begin
            pop_lfsr = lfsr_next(pop_lfsr);
            pop[i] = pop_lfsr[0];
         end else pop[i] = 1'b0;
      end
      if (!pop_random && manual_done != manual_target && !rd[0].empty) begin
         pop[0] = 1'b1;   // Directed pops on lane 0
         manual_done++;
      end
   end

   task automatic write_block(input int lane);
      primitive_pkg::block_t blk;
      int t;
      for (int b = 0; b < primitive_pkg::BLOCK_WIDTH; b++) begin
         data_lfsr = lfsr_next(data_lfsr);
         blk[b] = data_lfsr[0];
      end
      @(negedge clk_pll_200);
      wr[lane].data = blk;
      wr[lane].req = 1'b1;
      for (t = 0; t < 400 && !wr_ack[lane]; t++) @(negedge clk_pll_200);
      if (!wr_ack[lane]) report_problem("write ack never arrived");
      wr[lane].req = 1'b0;
      for (t = 0; t < 20 && wr_ack[lane]; t++) @(negedge clk_pll_200);
      if (wr_ack[lane]) report_problem("write ack never dropped");
   endtask

   task automatic wait_ready();
      int t;
      for (t = 0; t < 200 && !sys_ready; t++) @(negedge clk_pll_200);
      if (!sys_ready) report_problem("sys_ready never rose");
   endtask

   task automatic wait_drained();
      int t;
      for (t = 0; t < 4000 && !(&exp_empty); t++) @(negedge clk_pll_200);
      if (!(&exp_empty)) report_problem("lanes did not drain");
   endtask

   initial begin
      int t;
      rst_n = 1'b0;
      burst = 1'b0;
      flush = 1'b0;
      wr = '0;
      pop_random = 1'b0;
      repeat (5) @(negedge clk_pll_200);
      rst_n = 1'b1;
      wait_ready();
      burst = 1'b1;   // Start of burst with refill tracking
      pop_random = 1'b1;
      for (int r = 0; r < 6; r++)
         for (int l = 0; l < NL; l++) write_block(l);
      wait_drained();
      burst = 1'b0;
      repeat (8) @(negedge clk_pll_200);
      burst = 1'b1;   // Quick toggle restarts the marker
      repeat (2) @(negedge clk_pll_200);
      burst = 1'b0;
      repeat (10) @(negedge clk_pll_200);
      // Back-pressure on lane 0 with one block in the serializer
      pop_random = 1'b0;
      burst = 1'b1;
      for (int b = 0; b <= primitive_pkg::LANE_DEPTH; b++) write_block(0);
      fork
         write_block(0);
         begin
            repeat (6) @(negedge clk_pll_200);
            manual_target = manual_target + primitive_pkg::WORDS_PER_BLOCK;
            for (t = 0; t < 200 && manual_done != manual_target; t++) @(negedge clk_pll_200);
            if (manual_done != manual_target) report_problem("directed pops stalled");
         end
      join
      pop_random = 1'b1;
      wait_drained();
      // Flush with data left in lane 1 and refill raised
      pop_random = 1'b0;
      repeat (2) write_block(1);
      flush = 1'b1;
      repeat (2) @(negedge clk_pll_200);
      flush = 1'b0;
      wait_ready();
      write_block(2);
      pop_random = 1'b1;
      wait_drained();
      repeat (5) @(negedge clk_pll_200);
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/primitive_pkg.sv
verilog/lane_store.sv
verilog/word_serializer.sv
verilog/primitive_lane.sv
verilog/burst_marker.sv
verilog/reset_sequencer.sv
verilog/l0_buffer_top.sv
bench/l0_buffer_properties.sv
bench/tb_l0_buffer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_l0_buffer \
   -f project.f --Mdir obj_dir -o sim_l0_buffer
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_l0_buffer > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
   exit 1
fi
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi
exit 0
